/* include/image_gradient_settings.svh */
`ifndef IMAGE_GRADIENT_SETTINGS_SVH
`define IMAGE_GRADIENT_SETTINGS_SVH

// ---------------------------------------------------------------------------
// image geometry
// ---------------------------------------------------------------------------

// pixels per row
`define IMG_WIDTH 256

// rows per image
`define IMG_HEIGHT 256

// ---------------------------------------------------------------------------
// memory interface widths
// ---------------------------------------------------------------------------

`define ADDR_WIDTH 16
`define PIXEL_WIDTH 8

`endif

/* verilog/image_gradient_pkg.sv */
`include "image_gradient_settings.svh"

package image_gradient_pkg;

    // -----------------------------------------------------------------------
    // scalar types
    // -----------------------------------------------------------------------

    // unsigned grey level
    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

    // signed difference, two bits wider than a pixel
    typedef logic signed [`PIXEL_WIDTH+1:0] grad_t;

    // address into either memory
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // -----------------------------------------------------------------------
    // structured types
    // -----------------------------------------------------------------------

    // gradient memory word, horizontal half on top
    typedef struct packed {
        grad_t gx;
        grad_t gy;
    } gradient_word_t;

    // one item of the pixel stream out of the fetch stage
    typedef struct packed {
        logic   valid;
        // set for beats of the padding phase, value is meaningless then
        logic   pad;
        pixel_t value;
    } pixel_beat_t;

    // a pixel with the two neighbours needed for forward differences
    typedef struct packed {
        logic   valid;
        pixel_t centre;
        pixel_t right;
        pixel_t below;
        logic   last_col;
        logic   last_row;
    } window_t;

endpackage

/* verilog/pixel_fetch.sv */
`timescale 1ns/1ps

`include "image_gradient_settings.svh"

module pixel_fetch
    import image_gradient_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic        img_rd,
    output addr_t       img_addr,
    input  pixel_t      img_di,
    output pixel_beat_t beat
);

    localparam int CNT_W = $clog2(`IMG_WIDTH);
    localparam addr_t LAST_ADDR = addr_t'(`IMG_WIDTH * `IMG_HEIGHT - 1);
    localparam logic [CNT_W-1:0] PAD_LAST = CNT_W'(`IMG_WIDTH - 1);

    typedef enum logic [1:0] {
        PH_INIT,
        PH_READ,
        PH_PAD,
        PH_IDLE
    } phase_t;

    phase_t           phase;
    logic [CNT_W-1:0] pad_cnt;
    logic             pad_issue;
    // strobes delayed to line up with the memory data
    logic             rd_q;
    logic             pad_q;

    // ---------------------------------------------------------------------------
    // phase sequencer
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= PH_INIT;
            img_rd    <= 1'b0;
            img_addr  <= '0;
            pad_issue <= 1'b0;
            pad_cnt   <= '0;
            rd_q      <= 1'b0;
            pad_q     <= 1'b0;
        end else begin
            rd_q  <= img_rd;
            pad_q <= pad_issue;
            case (phase)
                PH_INIT: begin
                    // first read goes out right after reset
                    img_rd <= 1'b1;
                    phase  <= PH_READ;
                end
                PH_READ: begin
                    if (img_addr == LAST_ADDR) begin
                        img_rd    <= 1'b0;
                        pad_issue <= 1'b1;
                        phase     <= PH_PAD;
                    end else begin
                        img_addr <= img_addr + 1'b1;
                    end
                end
                PH_PAD: begin
                    // one extra row of beats flushes the last image row
                    if (pad_cnt == PAD_LAST) begin
                        pad_issue <= 1'b0;
                        phase     <= PH_IDLE;
                    end else begin
                        pad_cnt <= pad_cnt + 1'b1;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // beat follows the read by one cycle like the memory data
    assign beat.valid = rd_q | pad_q;
    assign beat.pad   = pad_q;
    assign beat.value = img_di;

    a_addr_in_range: assert property (@(posedge clk) disable iff (reset)
        img_rd |-> img_addr <= LAST_ADDR);

endmodule

/* verilog/row_window.sv */
`timescale 1ns/1ps

`include "image_gradient_settings.svh"

module row_window
    import image_gradient_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  pixel_beat_t beat,
    output window_t     window
);

    localparam int COL_W  = $clog2(`IMG_WIDTH);
    localparam int ROW_W  = $clog2(`IMG_HEIGHT);
    localparam int FILL_W = $clog2(`IMG_WIDTH + 1);

    localparam logic [COL_W-1:0]  COL_LAST = COL_W'(`IMG_WIDTH - 1);
    localparam logic [ROW_W-1:0]  ROW_LAST = ROW_W'(`IMG_HEIGHT - 1);
    localparam logic [FILL_W-1:0] FULL     = FILL_W'(`IMG_WIDTH);

    // line_buf[0] is the newest pixel, the top entry the oldest
    pixel_t line_buf [`IMG_WIDTH];

    logic [FILL_W-1:0] fill;
    logic [COL_W-1:0]  col;
    logic [ROW_W-1:0]  row;
    logic              row_full;
    logic              frame_done;

    // ---------------------------------------------------------------------------
    // one-row delay line
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            line_buf[0] <= beat.value;
            for (int i = 1; i < `IMG_WIDTH; i++) begin
                line_buf[i] <= line_buf[i-1];
            end
        end
    end

    // number of beats held, saturating at one row
    always_ff @(posedge clk) begin
        if (reset) begin
            fill <= '0;
        end else if (beat.valid && !row_full) begin
            fill <= fill + 1'b1;
        end
    end

    assign row_full = (fill == FULL);

    // ---------------------------------------------------------------------------
    // window assembly
    // ---------------------------------------------------------------------------

    always_comb begin
        window.valid    = beat.valid && row_full;
        window.centre   = line_buf[`IMG_WIDTH-1];
        window.right    = line_buf[`IMG_WIDTH-2];
        // nothing real below the last row
        window.below    = beat.pad ? '0 : beat.value;
        window.last_col = (col == COL_LAST);
        window.last_row = (row == ROW_LAST);
    end

    // position of the centre pixel in the image
    always_ff @(posedge clk) begin
        if (reset) begin
            col        <= '0;
            row        <= '0;
            frame_done <= 1'b0;
        end else if (window.valid) begin
            if (col == COL_LAST) begin
                col <= '0;
                if (row == ROW_LAST) begin
                    row        <= '0;
                    frame_done <= 1'b1;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // the stream dries up once the whole frame has gone out
    a_frame_limit: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> !window.valid);

    // pad beats from fetch must line up with the last row count here
    a_pad_is_last_row: assert property (@(posedge clk) disable iff (reset)
        window.valid |-> (window.last_row == beat.pad));

endmodule

/* verilog/gradient_calc.sv */
`timescale 1ns/1ps

module gradient_calc
    import image_gradient_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  window_t        window,
    output logic           grad_wr,
    output gradient_word_t grad_do
);

    grad_t gx;
    grad_t gy;

    // zero extension, so 255 stays positive
    function automatic grad_t widen(input pixel_t p);
        return grad_t'({2'b00, p});
    endfunction

    // ---------------------------------------------------------------------------
    // forward differences with the edge rule
    // ---------------------------------------------------------------------------

    always_comb begin
        if (window.last_col) begin
            gx = '0;
        end else begin
            gx = widen(window.right) - widen(window.centre);
        end

        if (window.last_row) begin
            gy = '0;
        end else begin
            gy = widen(window.below) - widen(window.centre);
        end
    end

    // write strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= window.valid;
        end
    end

    // packed result word
    always_ff @(posedge clk) begin
        grad_do.gx <= gx;
        grad_do.gy <= gy;
    end

endmodule

/* verilog/gradient_store.sv */
`timescale 1ns/1ps

`include "image_gradient_settings.svh"

module gradient_store
    import image_gradient_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  grad_wr,
    output addr_t grad_addr,
    output logic  done
);

    localparam addr_t LAST_ADDR = addr_t'(`IMG_WIDTH * `IMG_HEIGHT - 1);

    // address of the next write
    addr_t wr_cnt;

    // ---------------------------------------------------------------------------
    // write address and completion
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_cnt <= '0;
        end else if (grad_wr) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // one write per pixel in raster order
    assign grad_addr = wr_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (grad_wr && wr_cnt == LAST_ADDR) begin
            done <= 1'b1;
        end
    end

    // nothing may follow the final write of the image
    a_no_write_after_done: assert property (@(posedge clk) disable iff (reset)
        done |-> !grad_wr);

endmodule

/* verilog/image_gradient.sv */
`timescale 1ns/1ps

module image_gradient
    import image_gradient_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    // image memory, read only
    output logic           img_rd,
    output addr_t          img_addr,
    input  pixel_t         img_di,
    // gradient memory, write only
    output logic           grad_wr,
    output addr_t          grad_addr,
    output gradient_word_t grad_do,
    output logic           done
);

    pixel_beat_t beat;
    window_t     window;

    // ---------------------------------------------------------------------------
    // pixel stream
    // ---------------------------------------------------------------------------

    pixel_fetch pixel_fetch_i (
        .clk      (clk),
        .reset    (reset),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .beat     (beat)
    );

    row_window row_window_i (
        .clk    (clk),
        .reset  (reset),
        .beat   (beat),
        .window (window)
    );

    // ---------------------------------------------------------------------------
    // gradient output
    // ---------------------------------------------------------------------------

    gradient_calc gradient_calc_i (
        .clk     (clk),
        .reset   (reset),
        .window  (window),
        .grad_wr (grad_wr),
        .grad_do (grad_do)
    );

    gradient_store gradient_store_i (
        .clk       (clk),
        .reset     (reset),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .done      (done)
    );

endmodule

/* dv/image_gradient_tb.sv */
`timescale 1ns/1ps

`include "image_gradient_settings.svh"

module image_gradient_tb
    import image_gradient_pkg::*;
();

    localparam int TOTAL       = `IMG_WIDTH * `IMG_HEIGHT;
    localparam int LAST        = TOTAL - 1;
    localparam int CYCLE_LIMIT = 5 * (`IMG_WIDTH * (`IMG_HEIGHT + 1) + 20);
    localparam int IMG_RANDOM  = 0;
    localparam int IMG_CHECKER = 1;

    logic           clk;
    logic           reset;
    logic           img_rd;
    addr_t          img_addr;
    pixel_t         img_di;
    logic           grad_wr;
    addr_t          grad_addr;
    gradient_word_t grad_do;
    logic           done;

    // memory models and scoreboard state
    pixel_t         image_mem [TOTAL];
    gradient_word_t grad_mem [TOTAL];
    int             write_count [TOTAL];
    int             writes_done = 0;
    int             reads_done = 0;
    logic           done_exp = 1'b0;
    int             cycle_count = 0;
    int             error_count = 0;
    int             seed = 43805;

    image_gradient image_gradient_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // reporting and compare tasks
    // ------------------------------------------------------------------------

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_gradient(input gradient_word_t got, input gradient_word_t exp,
                                  input string what);
        if (got !== exp) begin
            report_failure($sformatf(
                "FAILED at time %0t: %s, got gx %0d gy %0d, expected gx %0d gy %0d",
                $time, what, got.gx, got.gy, exp.gx, exp.gy));
        end
    endtask

    task automatic check_field(input grad_t got, input grad_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at time %0t: %s, got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at time %0t: %s, got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at time %0t: %s, got %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_failure($sformatf("FAILED at time %0t: %s, got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    // forward differences with zero on the right and bottom borders
    function automatic gradient_word_t expected_gradient(input int a);
        int             row;
        int             col;
        int             centre;
        gradient_word_t w;
        row    = a / `IMG_WIDTH;
        col    = a % `IMG_WIDTH;
        centre = int'(image_mem[a]);
        w.gx   = '0;
        w.gy   = '0;
        if (col != `IMG_WIDTH - 1) begin
            w.gx = grad_t'(int'(image_mem[a + 1]) - centre);
        end
        if (row != `IMG_HEIGHT - 1) begin
            w.gy = grad_t'(int'(image_mem[a + `IMG_WIDTH]) - centre);
        end
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // memory models and monitors
    // ------------------------------------------------------------------------

    // image memory with one cycle of read latency
    always @(posedge clk) begin
        if (img_rd === 1'b1) begin
            img_di <= image_mem[img_addr];
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            reads_done = 0;
        end else if (img_rd === 1'b1) begin
            if (int'(img_addr) > LAST || reads_done >= TOTAL) begin
                report_failure("image read issued past the last pixel of the image");
            end
            check_addr(img_addr, addr_t'(reads_done), "image read address");
            reads_done++;
        end
    end

    // gradient memory with the on-the-fly compare
    always @(posedge clk) begin
        if (reset) begin
            writes_done = 0;
            done_exp    = 1'b0;
        end else begin
            check_level(done, done_exp, "done level");
            if (grad_wr === 1'b1) begin
                if (writes_done >= TOTAL) begin
                    report_failure("gradient write seen after the last pixel was written");
                end
                check_addr(grad_addr, addr_t'(writes_done), "gradient write address");
                check_gradient(grad_do, expected_gradient(int'(grad_addr)),
                               $sformatf("gradient word at address %0d", grad_addr));
                grad_mem[grad_addr] = grad_do;
                write_count[grad_addr]++;
                writes_done++;
                if (int'(grad_addr) == LAST) begin
                    done_exp = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            report_failure($sformatf("timeout: the run did not finish within %0d cycles",
                                     CYCLE_LIMIT));
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    task automatic load_image(input int kind);
        for (int a = 0; a < TOTAL; a++) begin
            if (kind == IMG_CHECKER) begin
                image_mem[a] = ((a / `IMG_WIDTH + a % `IMG_WIDTH) % 2) ? 8'd255 : 8'd0;
            end else begin
                image_mem[a] = pixel_t'($random(seed));
            end
            grad_mem[a]    = '0;
            write_count[a] = 0;
        end
    endtask

    // three cycles of reset with the new image loaded while nothing is read
    task automatic reset_and_load(input int kind);
        reset <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        load_image(kind);
        @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_level(done, 1'b0, "done right after reset");
    endtask

    task automatic wait_for_done();
        while (done !== 1'b1) begin
            @(posedge clk);
        end
        // done has to stay up with no further writes
        repeat (10) @(posedge clk);
    endtask

    task automatic verify_result();
        check_gradient(grad_mem[LAST], '0, "bottom-right pixel");
        for (int a = 0; a < TOTAL; a++) begin
            check_count(write_count[a], 1, $sformatf("writes to address %0d", a));
            if (a % `IMG_WIDTH == `IMG_WIDTH - 1) begin
                check_field(grad_mem[a].gx, '0, $sformatf("gx in last column %0d", a));
            end
            if (a / `IMG_WIDTH == `IMG_HEIGHT - 1) begin
                check_field(grad_mem[a].gy, '0, $sformatf("gy in last row %0d", a));
            end
        end
        check_count(reads_done, TOTAL, "image reads in the run");
        check_count(writes_done, TOTAL, "gradient writes in the run");
    endtask

    initial begin
        reset  = 1'b1;
        img_di = '0;

        // random image
        reset_and_load(IMG_RANDOM);
        wait_for_done();
        verify_result();

        // checkerboard gives full-scale differences of both signs
        reset_and_load(IMG_CHECKER);
        wait_for_done();
        verify_result();
        check_gradient(grad_mem[0], gradient_word_t'{gx: 10'sd255, gy: 10'sd255},
                       "checkerboard rising step");
        check_gradient(grad_mem[1], gradient_word_t'{gx: -10'sd255, gy: -10'sd255},
                       "checkerboard falling step");

        // abort a run part way and follow with a clean run on a new image
        reset_and_load(IMG_RANDOM);
        while (int'(grad_addr) < TOTAL / 3) begin
            @(posedge clk);
        end
        reset_and_load(IMG_RANDOM);
        wait_for_done();
        verify_result();

        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* image_gradient.f */
+incdir+include
verilog/image_gradient_pkg.sv
verilog/pixel_fetch.sv
verilog/row_window.sv
verilog/gradient_calc.sv
verilog/gradient_store.sv
verilog/image_gradient.sv
dv/image_gradient_tb.sv
